// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cache_top
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+.
cache_pkg.sv
cache_store.sv
cache_driver.sv
line_biu.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

// ==== cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// processor word width in bits.
`define DATA_WIDTH 32

// byte address width of the processor and memory ports.
`define ADDR_WIDTH 16

// total data capacity in bytes.
`define CACHE_SIZE 256

// line size in bytes.
`define CACHE_LINE_SIZE 16

// cycles from a memory request to its ack in the memory model.
`define MEM_LATENCY 3

`endif

// ==== cache_driver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_driver #(
    localparam int DW       = `DATA_WIDTH,
    localparam int AW       = `ADDR_WIDTH,
    localparam int OFFSET_W = $clog2(`CACHE_LINE_SIZE),
    localparam int INDEX_W  = $clog2(`CACHE_SIZE / `CACHE_LINE_SIZE),
    localparam int TAG_W    = AW - INDEX_W - OFFSET_W,
    localparam int LINE_W   = `CACHE_LINE_SIZE * 8
) (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_re,
    input  logic                   i_we,
    input  logic [AW-1:0]          i_addr,
    input  logic [DW-1:0]          i_wdata,

    input  logic                   i_store_hit,
    input  logic                   i_victim_valid,
    input  logic                   i_victim_dirty,
    input  logic [TAG_W-1:0]       i_victim_tag,
    input  logic [LINE_W-1:0]      i_victim_line,
    input  logic                   i_line_done,

    output cache_pkg::cache_addr_u o_store_addr,
    output logic [DW-1:0]          o_store_wdata,
    output logic                   o_store_rd,
    output logic                   o_store_wr,
    output logic                   o_store_fill,

    output logic                   o_line_req,
    output logic                   o_line_we,
    output cache_pkg::cache_addr_u o_line_addr,
    output logic [LINE_W-1:0]      o_line_wdata,

    output logic                   o_hit,
    output logic                   o_done,
    output logic                   o_busy
);

    cache_pkg::drv_state_t  state;
    cache_pkg::drv_state_t  state_nxt;

    cache_pkg::cache_addr_u addr_q;
    cache_pkg::cache_addr_u fill_addr;
    cache_pkg::cache_addr_u victim_addr;
    logic [DW-1:0]          wdata_q;
    logic [TAG_W-1:0]       vtag_q;
    logic [LINE_W-1:0]      vline_q;

    logic re_q;
    logic we_q;
    logic hit_q;
    logic done_q;
    logic line_req_q;
    logic vict_q;
    logic idle;
    logic strobe;
    logic replay;

    assign idle   = (state == cache_pkg::DRV_IDLE);
    assign replay = (state == cache_pkg::DRV_REPLAY);
    assign strobe = i_re || i_we;

    // the store sees the live request while idle so hits finish in one cycle.
    always_comb begin
        if (idle) begin
            o_store_addr.flat = i_addr;
            o_store_wdata     = i_wdata;
        end else begin
            o_store_addr  = addr_q;
            o_store_wdata = wdata_q;
        end
    end

    assign o_store_rd   = (idle && i_re && i_store_hit) || (replay && re_q);
    assign o_store_wr   = (idle && i_we && i_store_hit) || (replay && we_q);
    assign o_store_fill = (state == cache_pkg::DRV_FILL) && i_line_done;

    always_comb begin
        fill_addr            = addr_q;
        fill_addr.f.offset   = '0;
        victim_addr.f.tag    = vtag_q;
        victim_addr.f.index  = addr_q.f.index;
        victim_addr.f.offset = '0;
    end

    assign o_line_req   = line_req_q;
    assign o_line_we    = (state == cache_pkg::DRV_VICTIM);
    assign o_line_addr  = o_line_we ? victim_addr : fill_addr;
    assign o_line_wdata = vline_q;

    assign o_hit  = hit_q;
    assign o_done = done_q;
    assign o_busy = !idle;

    always_comb begin
        state_nxt = state;
        unique case (state)
            cache_pkg::DRV_IDLE: begin
                if (strobe && !i_store_hit) begin
                    state_nxt = cache_pkg::DRV_FILL;
                end
            end
            cache_pkg::DRV_FILL: begin
                if (i_line_done) begin
                    state_nxt = cache_pkg::DRV_REPLAY;
                end
            end
            cache_pkg::DRV_REPLAY: begin
                state_nxt = vict_q ? cache_pkg::DRV_VICTIM : cache_pkg::DRV_IDLE;
            end
            cache_pkg::DRV_VICTIM: begin
                if (i_line_done) begin
                    state_nxt = cache_pkg::DRV_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state      <= cache_pkg::DRV_IDLE;
            re_q       <= 1'b0;
            we_q       <= 1'b0;
            hit_q      <= 1'b0;
            done_q     <= 1'b0;
            line_req_q <= 1'b0;
            vict_q     <= 1'b0;
        end else begin
            state <= state_nxt;
            // done lands in the first idle cycle after the access.
            done_q <= (idle && strobe && i_store_hit) || (replay && !vict_q)
                   || (o_line_we && i_line_done);
            line_req_q <= (idle && strobe && !i_store_hit) || (replay && vict_q);
            if (idle && strobe) begin
                re_q  <= i_re;
                we_q  <= i_we;
                hit_q <= i_store_hit;
            end
            if (o_store_fill) begin
                vict_q <= i_victim_valid && i_victim_dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (idle && strobe) begin
            addr_q.flat <= i_addr;
            wdata_q     <= i_wdata;
        end
        if (o_store_fill) begin
            vtag_q  <= i_victim_tag;
            vline_q <= i_victim_line;
        end
    end

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!n_rst)
        o_busy |-> !(i_re || i_we));

    // line done only answers the transfer in flight.
    a_line_done_owned: assert property (@(posedge clk) disable iff (!n_rst)
        i_line_done |-> (state == cache_pkg::DRV_FILL || state == cache_pkg::DRV_VICTIM)
                        && !o_line_req);

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

    localparam int OFFSET_W = $clog2(`CACHE_LINE_SIZE);
    localparam int INDEX_W  = $clog2(`CACHE_SIZE / `CACHE_LINE_SIZE);
    localparam int TAG_W    = `ADDR_WIDTH - INDEX_W - OFFSET_W;

    // one address word, seen flat by the bus side and split by the lookup side.
    typedef union packed {
        logic [`ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
        } f;
    } cache_addr_u;

    typedef enum logic [1:0] {
        DRV_IDLE   = 2'b00,
        DRV_FILL   = 2'b01,
        DRV_REPLAY = 2'b10,
        DRV_VICTIM = 2'b11
    } drv_state_t;

endpackage

`default_nettype wire

// ==== cache_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_store #(
    localparam int DW       = `DATA_WIDTH,
    localparam int AW       = `ADDR_WIDTH,
    localparam int LINES    = `CACHE_SIZE / `CACHE_LINE_SIZE,
    localparam int OFFSET_W = $clog2(`CACHE_LINE_SIZE),
    localparam int INDEX_W  = $clog2(LINES),
    localparam int TAG_W    = AW - INDEX_W - OFFSET_W,
    localparam int WORDS    = `CACHE_LINE_SIZE / (DW / 8),
    localparam int WORD_W   = $clog2(WORDS),
    localparam int BYTE_W   = OFFSET_W - WORD_W,
    localparam int LINE_W   = `CACHE_LINE_SIZE * 8
) (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_rd_en,
    input  logic                   i_wr_en,
    input  logic                   i_fill_en,
    input  cache_pkg::cache_addr_u i_addr,
    input  logic [DW-1:0]          i_wdata,
    input  logic [LINE_W-1:0]      i_fill_line,

    output logic                   o_hit,
    output logic                   o_victim_valid,
    output logic                   o_victim_dirty,
    output logic [TAG_W-1:0]       o_victim_tag,
    output logic [LINE_W-1:0]      o_victim_line,
    output logic [DW-1:0]          o_rdata
);

    logic [TAG_W-1:0]   tag_mem  [LINES];
    logic [LINE_W-1:0]  data_mem [LINES];
    logic [LINES-1:0]   valid;
    logic [LINES-1:0]   dirty;

    logic [INDEX_W-1:0] idx;
    logic [WORD_W-1:0]  word;

    assign idx  = i_addr.f.index;
    assign word = i_addr.f.offset[OFFSET_W-1:BYTE_W];

    assign o_hit = valid[idx] && (tag_mem[idx] == i_addr.f.tag);

    // indexed line as it stands before any fill on this edge.
    assign o_victim_valid = valid[idx];
    assign o_victim_dirty = dirty[idx];
    assign o_victim_tag   = tag_mem[idx];
    assign o_victim_line  = data_mem[idx];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (i_fill_en) begin
            valid[idx] <= 1'b1;
            dirty[idx] <= 1'b0;
        end else if (i_wr_en) begin
            dirty[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            tag_mem[idx]  <= i_addr.f.tag;
            data_mem[idx] <= i_fill_line;
        end else if (i_wr_en) begin
            data_mem[idx][word*DW +: DW] <= i_wdata;
        end
    end

    // registered read port.
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rdata <= data_mem[idx][word*DW +: DW];
        end
    end

    // fill and replayed write come from different driver states.
    a_fill_write_excl: assert property (@(posedge clk) disable iff (!n_rst)
        !(i_fill_en && i_wr_en));

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_top #(
    localparam int DW       = `DATA_WIDTH,
    localparam int AW       = `ADDR_WIDTH,
    localparam int OFFSET_W = $clog2(`CACHE_LINE_SIZE),
    localparam int INDEX_W  = $clog2(`CACHE_SIZE / `CACHE_LINE_SIZE),
    localparam int TAG_W    = AW - INDEX_W - OFFSET_W,
    localparam int LINE_W   = `CACHE_LINE_SIZE * 8
) (
    input  logic          clk,
    input  logic          n_rst,

    input  logic          i_re,
    input  logic          i_we,
    input  logic [AW-1:0] i_addr,
    input  logic [DW-1:0] i_wdata,
    output logic [DW-1:0] o_rdata,
    output logic          o_hit,
    output logic          o_done,
    output logic          o_busy,

    output logic          o_mem_req,
    output logic          o_mem_we,
    output logic [AW-1:0] o_mem_addr,
    output logic [DW-1:0] o_mem_wdata,
    input  logic          i_mem_ack,
    input  logic [DW-1:0] i_mem_rdata
);

    cache_pkg::cache_addr_u store_addr;
    cache_pkg::cache_addr_u line_addr;
    logic [DW-1:0]          store_wdata;
    logic                   store_rd;
    logic                   store_wr;
    logic                   store_fill;
    logic                   store_hit;
    logic                   victim_valid;
    logic                   victim_dirty;
    logic [TAG_W-1:0]       victim_tag;
    logic [LINE_W-1:0]      victim_line;
    logic                   line_req;
    logic                   line_we;
    logic [LINE_W-1:0]      line_wdata;
    logic [LINE_W-1:0]      line_rdata;
    logic                   line_done;

    cache_driver i_cache_driver (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_re           (i_re),
        .i_we           (i_we),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_store_hit    (store_hit),
        .i_victim_valid (victim_valid),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .i_victim_line  (victim_line),
        .i_line_done    (line_done),
        .o_store_addr   (store_addr),
        .o_store_wdata  (store_wdata),
        .o_store_rd     (store_rd),
        .o_store_wr     (store_wr),
        .o_store_fill   (store_fill),
        .o_line_req     (line_req),
        .o_line_we      (line_we),
        .o_line_addr    (line_addr),
        .o_line_wdata   (line_wdata),
        .o_hit          (o_hit),
        .o_done         (o_done),
        .o_busy         (o_busy)
    );

    cache_store i_cache_store (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_rd_en        (store_rd),
        .i_wr_en        (store_wr),
        .i_fill_en      (store_fill),
        .i_addr         (store_addr),
        .i_wdata        (store_wdata),
        .i_fill_line    (line_rdata),
        .o_hit          (store_hit),
        .o_victim_valid (victim_valid),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .o_victim_line  (victim_line),
        .o_rdata        (o_rdata)
    );

    line_biu i_line_biu (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_line_req   (line_req),
        .i_line_we    (line_we),
        .i_line_addr  (line_addr),
        .i_line_wdata (line_wdata),
        .o_line_rdata (line_rdata),
        .o_line_done  (line_done),
        .o_mem_req    (o_mem_req),
        .o_mem_we     (o_mem_we),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .i_mem_ack    (i_mem_ack),
        .i_mem_rdata  (i_mem_rdata)
    );

endmodule

`default_nettype wire

// ==== line_biu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module line_biu #(
    localparam int DW       = `DATA_WIDTH,
    localparam int AW       = `ADDR_WIDTH,
    localparam int OFFSET_W = $clog2(`CACHE_LINE_SIZE),
    localparam int WORDS    = `CACHE_LINE_SIZE / (DW / 8),
    localparam int WORD_W   = $clog2(WORDS),
    localparam int BYTE_W   = OFFSET_W - WORD_W,
    localparam int LINE_W   = `CACHE_LINE_SIZE * 8
) (
    input  logic                   clk,
    input  logic                   n_rst,

    input  logic                   i_line_req,
    input  logic                   i_line_we,
    input  cache_pkg::cache_addr_u i_line_addr,
    input  logic [LINE_W-1:0]      i_line_wdata,
    output logic [LINE_W-1:0]      o_line_rdata,
    output logic                   o_line_done,

    output logic                   o_mem_req,
    output logic                   o_mem_we,
    output logic [AW-1:0]          o_mem_addr,
    output logic [DW-1:0]          o_mem_wdata,
    input  logic                   i_mem_ack,
    input  logic [DW-1:0]          i_mem_rdata
);

    cache_pkg::cache_addr_u base_q;
    cache_pkg::cache_addr_u beat_addr;
    logic [LINE_W-1:0]      wline_q;
    logic [LINE_W-1:0]      line_q;
    logic [WORD_W-1:0]      beat;
    logic                   we_q;
    logic                   last_beat;
    logic                   beat_ack;

    assign last_beat = (beat == WORD_W'(WORDS - 1));
    assign beat_ack  = o_mem_req && i_mem_ack;

    always_comb begin
        beat_addr          = base_q;
        beat_addr.f.offset = {beat, {BYTE_W{1'b0}}};
    end

    assign o_mem_addr   = beat_addr.flat;
    assign o_mem_we     = we_q;
    assign o_mem_wdata  = wline_q[beat*DW +: DW];
    assign o_line_rdata = line_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_mem_req   <= 1'b0;
            o_line_done <= 1'b0;
            beat        <= '0;
            we_q        <= 1'b0;
        end else begin
            o_line_done <= beat_ack && last_beat;
            if (i_line_req) begin
                o_mem_req <= 1'b1;
                beat      <= '0;
                we_q      <= i_line_we;
            end else if (beat_ack) begin
                // req stays up and the next beat's address follows the ack.
                if (last_beat) begin
                    o_mem_req <= 1'b0;
                end
                beat <= beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_line_req) begin
            base_q  <= i_line_addr;
            wline_q <= i_line_wdata;
        end
        if (beat_ack && !we_q) begin
            line_q[beat*DW +: DW] <= i_mem_rdata;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!n_rst)
        i_mem_ack |-> o_mem_req);

endmodule

`default_nettype wire

// ==== tb_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_cache_top;

    localparam int DW       = `DATA_WIDTH;
    localparam int AW       = `ADDR_WIDTH;
    localparam int BYTE_W   = $clog2(DW / 8);
    localparam int OFFSET_W = $clog2(`CACHE_LINE_SIZE);
    localparam int LINES    = `CACHE_SIZE / `CACHE_LINE_SIZE;
    localparam int INDEX_W  = $clog2(LINES);
    localparam int TAG_W    = AW - INDEX_W - OFFSET_W;
    localparam int LWORDS   = `CACHE_LINE_SIZE / (DW / 8);
    localparam int MWORDS   = 1 << (AW - BYTE_W);
    localparam int ENTRY_W  = 1 + AW + DW;
    localparam int N_TBL    = 15;
    localparam int N_RAND   = 40;
    localparam int TIMEOUT_CYCLES = (N_TBL + N_RAND) * 60;

    // {write, address, write data}.
    localparam logic [ENTRY_W-1:0] OPS [N_TBL] = '{
        {1'b0, 16'h0040, 32'h0000_0000},
        {1'b0, 16'h0044, 32'h0000_0000},
        {1'b1, 16'h0048, 32'hDEAD_BEEF},
        {1'b0, 16'h0048, 32'h0000_0000},
        {1'b0, 16'h0140, 32'h0000_0000},
        {1'b0, 16'h0048, 32'h0000_0000},
        {1'b0, 16'h004C, 32'h0000_0000},
        {1'b1, 16'h0230, 32'h1234_5678},
        {1'b0, 16'h0230, 32'h0000_0000},
        {1'b1, 16'h0334, 32'hCAFE_F00D},
        {1'b0, 16'h0230, 32'h0000_0000},
        {1'b0, 16'h0334, 32'h0000_0000},
        {1'b1, 16'h00F0, 32'h0BAD_CAFE},
        {1'b0, 16'h01F0, 32'h0000_0000},
        {1'b0, 16'h00FC, 32'h0000_0000}
    };

    logic          clk;
    logic          n_rst;
    logic          cpu_re;
    logic          cpu_we;
    logic [AW-1:0] cpu_addr;
    logic [DW-1:0] cpu_wdata;
    logic [DW-1:0] cpu_rdata;
    logic          cpu_hit;
    logic          cpu_done;
    logic          cpu_busy;
    logic          mem_req;
    logic          mem_we;
    logic [AW-1:0] mem_addr;
    logic [DW-1:0] mem_wdata;
    logic          mem_ack;
    logic [DW-1:0] mem_rdata;
    logic [31:0]   wr_beats;

    // shadow of what the processor should see.
    logic [DW-1:0]    shadow_mem [MWORDS];
    logic [TAG_W-1:0] sh_tag     [LINES];
    logic [LINES-1:0] sh_valid;
    logic [LINES-1:0] sh_dirty;
    int unsigned      exp_wr_cnt [MWORDS];
    logic [31:0]      exp_wr_total;

    int     n_checks;
    int     n_errors;
    int     cycles;
    integer seed;

    cache_top i_cache_top (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_re        (cpu_re),
        .i_we        (cpu_we),
        .i_addr      (cpu_addr),
        .i_wdata     (cpu_wdata),
        .o_rdata     (cpu_rdata),
        .o_hit       (cpu_hit),
        .o_done      (cpu_done),
        .o_busy      (cpu_busy),
        .o_mem_req   (mem_req),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata)
    );

    tb_mem_model i_mem_model (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_req      (mem_req),
        .i_we       (mem_we),
        .i_addr     (mem_addr),
        .i_wdata    (mem_wdata),
        .o_ack      (mem_ack),
        .o_rdata    (mem_rdata),
        .o_wr_beats (wr_beats)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the cache did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic run_op(input logic we, input logic [AW-1:0] addr, input logic [DW-1:0] wdata);
        logic [INDEX_W-1:0]   idx;
        logic [TAG_W-1:0]     tag;
        logic [AW-BYTE_W-1:0] w;
        logic [AW-1:0]        vbase;
        logic                 exp_hit;
        logic                 evict;
        int                   vw;
        int                   lat;
        idx     = addr[OFFSET_W +: INDEX_W];
        tag     = addr[AW-1 -: TAG_W];
        w       = addr[AW-1:BYTE_W];
        exp_hit = sh_valid[idx] && (sh_tag[idx] == tag);
        evict   = !exp_hit && sh_valid[idx] && sh_dirty[idx];
        vbase   = {sh_tag[idx], idx, {OFFSET_W{1'b0}}};
        vw      = int'(vbase[AW-1:BYTE_W]);
        if (!exp_hit) begin
            if (evict) begin
                for (int k = 0; k < LWORDS; k++) begin
                    exp_wr_cnt[vw + k]++;
                end
                exp_wr_total = exp_wr_total + LWORDS;
            end
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
            sh_tag[idx]   = tag;
        end

        @(negedge clk);
        check("busy before issue", 32'(cpu_busy), 32'd0);
        cpu_re    = !we;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        @(negedge clk);
        cpu_re = 1'b0;
        cpu_we = 1'b0;
        if (!exp_hit) begin
            check($sformatf("busy after miss %h", addr), 32'(cpu_busy), 32'd1);
        end
        lat = 1;
        while (!cpu_done) begin
            @(negedge clk);
            lat++;
        end

        check($sformatf("hit flag %h", addr), 32'(cpu_hit), 32'(exp_hit));
        if (exp_hit) begin
            check($sformatf("hit latency %h", addr), 32'(lat), 32'd1);
        end
        if (!we) begin
            check($sformatf("read data %h", addr), cpu_rdata, shadow_mem[w]);
        end else begin
            shadow_mem[w] = wdata;
            sh_dirty[idx] = 1'b1;
        end
        check("write beat total", wr_beats, exp_wr_total);
        if (evict) begin
            for (int k = 0; k < LWORDS; k++) begin
                check($sformatf("write beats word %0d", vw + k),
                      i_mem_model.wr_cnt[vw + k], exp_wr_cnt[vw + k]);
            end
        end
    endtask

    initial begin
        logic [ENTRY_W-1:0] entry;
        logic [31:0]        rnd;
        logic [AW-1:0]      raddr;
        logic               rwe;
        clk          = 1'b0;
        n_rst        = 1'b0;
        cpu_re       = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        n_checks     = 0;
        n_errors     = 0;
        cycles       = 0;
        seed         = 43;
        sh_valid     = '0;
        sh_dirty     = '0;
        exp_wr_total = '0;
        for (int i = 0; i < MWORDS; i++) begin
            shadow_mem[i] = DW'({i[AW-BYTE_W-1:0], {BYTE_W{1'b0}}} ^ 16'hA5A5);
            exp_wr_cnt[i] = 0;
        end
        for (int i = 0; i < LINES; i++) begin
            sh_tag[i] = '0;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        for (int n = 0; n < N_TBL; n++) begin
            entry = OPS[n];
            run_op(entry[AW+DW], entry[DW +: AW], entry[DW-1:0]);
        end

        // random word accesses over a 1 KB window, four lines per index.
        for (int n = 0; n < N_RAND; n++) begin
            rnd   = $random(seed);
            raddr = rnd[AW-1:0] & 16'h03FC;
            rwe   = rnd[16];
            rnd   = $random(seed);
            run_op(rwe, raddr, rnd);
        end

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_mem_model #(
    localparam int DW     = `DATA_WIDTH,
    localparam int AW     = `ADDR_WIDTH,
    localparam int BYTE_W = $clog2(DW / 8),
    localparam int WORDS  = 1 << (AW - BYTE_W)
) (
    input  logic          clk,
    input  logic          n_rst,
    input  logic          i_req,
    input  logic          i_we,
    input  logic [AW-1:0] i_addr,
    input  logic [DW-1:0] i_wdata,
    output logic          o_ack,
    output logic [DW-1:0] o_rdata,
    output logic [31:0]   o_wr_beats
);

    logic [DW-1:0]        mem [WORDS];
    int unsigned          wr_cnt [WORDS];
    int                   wait_cnt;
    logic [AW-BYTE_W-1:0] word;

    assign word = i_addr[AW-1:BYTE_W];

    // untouched words hold their byte address xor a5a5.
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i]    = DW'({i[AW-BYTE_W-1:0], {BYTE_W{1'b0}}} ^ 16'hA5A5);
            wr_cnt[i] = 0;
        end
    end

    // runs on the falling edge so the cache samples stable ack and data.
    always @(negedge clk or negedge n_rst) begin
        if (!n_rst) begin
            o_ack      <= 1'b0;
            o_rdata    <= '0;
            o_wr_beats <= '0;
            wait_cnt   <= 0;
        end else if (o_ack) begin
            o_ack    <= 1'b0;
            wait_cnt <= 0;
        end else if (i_req) begin
            if (wait_cnt == `MEM_LATENCY - 1) begin
                o_ack   <= 1'b1;
                o_rdata <= mem[word];
                if (i_we) begin
                    mem[word]    <= i_wdata;
                    wr_cnt[word] <= wr_cnt[word] + 1;
                    o_wr_beats   <= o_wr_beats + 1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else begin
            wait_cnt <= 0;
        end
    end

endmodule

`default_nettype wire
